// ==== design/sdram_consts.svh ====
// Bus widths, slot count and graphics bank layout, included by the packages and the RTL
`ifndef SDRAM_CONSTS_SVH
`define SDRAM_CONSTS_SVH

// One slot per video layer
`define SLOTS 4

// Bank word address and layer-relative word address widths
`define BA_AW 22
`define GFX_AW 18

// Pixel-row word width
`define DW 32

// Start of each layer's region, in bank words
`define CHAR_OFFSET 22'h00_0000
`define SCR1_OFFSET 22'h00_8000
`define SCR2_OFFSET 22'h02_8000
`define OBJ_OFFSET  22'h04_8000

// Region sizes in words
// Both scroll layers share one size
`define CHAR_SIZE 19'h0_8000
`define SCR_SIZE  19'h2_0000
`define OBJ_SIZE  19'h4_0000

`endif

// ==== design/sdram_pkg.sv ====
// Types for the read-only SDRAM bank port, shared by the arbiter, the slots and the testbench
`default_nettype none

`include "sdram_consts.svh"

package sdram_pkg;

    // Word address inside the bank
    typedef logic [`BA_AW-1:0] ba_addr_t;

    // One pixel-row word as read from the bank
    typedef logic [`DW-1:0] word_t;

    // Controller side of the bank
    // rd stays high until ack, addr is held with it
    typedef struct packed {
        logic     rd;
        ba_addr_t addr;
    } bank_req_t;

    // Bank side
    // ack takes the request, rdy marks valid data
    // Both are single-cycle pulses
    typedef struct packed {
        logic  ack;
        logic  rdy;
        word_t data;
    } bank_rsp_t;

endpackage

`default_nettype wire

// ==== design/gfx_pkg.sv ====
// Types for the video layers' ROM requests and replies, used by the bus top level and slots
`default_nettype none

`include "sdram_consts.svh"

package gfx_pkg;

    // Word address relative to a layer's region
    typedef logic [`GFX_AW-1:0] gfx_addr_t;

    // Slot index of each layer
    typedef enum logic [1:0] {
        CHAR = 2'd0,
        SCR1 = 2'd1,
        SCR2 = 2'd2,
        OBJ  = 2'd3
    } layer_t;

    // What a layer drives
    typedef struct packed {
        logic      cs;
        gfx_addr_t addr;
    } gfx_req_t;

    // What a layer gets back
    typedef struct packed {
        logic             ok;
        sdram_pkg::word_t data;
    } gfx_rsp_t;

    // Registered request with the absolute bank address
    typedef struct packed {
        logic                cs;
        sdram_pkg::ba_addr_t addr;
    } slot_req_t;

endpackage

`default_nettype wire

// ==== design/rom_region_map.sv ====
// Registers the four layer requests and places each in its own region of the graphics bank
`default_nettype none

`include "sdram_consts.svh"

module rom_region_map (
    input  logic                clk,
    input  logic                rst_n,
    input  gfx_pkg::gfx_req_t   gfx_req  [`SLOTS],
    output gfx_pkg::slot_req_t  slot_req [`SLOTS]
);

    // Region start for a layer
    function automatic sdram_pkg::ba_addr_t region_base(input gfx_pkg::layer_t layer);
        case (layer)
            gfx_pkg::CHAR: region_base = `CHAR_OFFSET;
            gfx_pkg::SCR1: region_base = `SCR1_OFFSET;
            gfx_pkg::SCR2: region_base = `SCR2_OFFSET;
            default:       region_base = `OBJ_OFFSET;
        endcase
    endfunction

    // Region length for a layer, one bit wider than the relative address
    function automatic logic [`GFX_AW:0] region_size(input gfx_pkg::layer_t layer);
        case (layer)
            gfx_pkg::CHAR: region_size = `CHAR_SIZE;
            gfx_pkg::OBJ:  region_size = `OBJ_SIZE;
            default:       region_size = `SCR_SIZE;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        for (int i = 0; i < `SLOTS; i++) begin
            if (!rst_n) begin
                slot_req[i].cs <= 1'b0;
            end else begin
                slot_req[i].cs   <= gfx_req[i].cs;
                // Relative address is zero-extended before the offset is added
                slot_req[i].addr <= region_base(gfx_pkg::layer_t'(i))
                                  + sdram_pkg::ba_addr_t'(gfx_req[i].addr);
            end
        end
    end

    // A layer must not reach past its own region into the next one
    for (genvar g = 0; g < `SLOTS; g++) begin : g_range
        a_in_region: assert property (
            @(posedge clk) disable iff (!rst_n)
            gfx_req[g].cs |-> ({1'b0, gfx_req[g].addr} < region_size(gfx_pkg::layer_t'(g)))
        );
    end

endmodule

`default_nettype wire

// ==== design/rom_slot.sv ====
// One-word cache for a video layer that asks the bank arbiter for a refill on an address miss
`default_nettype none

`include "sdram_consts.svh"

module rom_slot (
    input  logic                clk,
    input  logic                rst_n,
    input  gfx_pkg::slot_req_t  slot_req,
    output logic                req,
    output sdram_pkg::ba_addr_t req_addr,
    input  logic                done,
    input  sdram_pkg::word_t    fill,
    output gfx_pkg::gfx_rsp_t   rsp
);

    // Address and contents of the stored word
    sdram_pkg::ba_addr_t tag;
    sdram_pkg::word_t    cached;
    logic                valid;
    logic                ok;

    logic hit;
    logic miss;

    assign hit  = valid && (slot_req.addr == tag);
    assign miss = slot_req.cs && !hit;

    // Control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req   <= 1'b0;
            valid <= 1'b0;
            ok    <= 1'b0;
        end else begin
            if (done) begin
                req   <= 1'b0;
                valid <= 1'b1;
            end else if (miss && !req) begin
                req <= 1'b1;
            end
            // On a fill the old tag is stale, so compare against the word arriving
            if (done) begin
                ok <= slot_req.cs && (slot_req.addr == req_addr);
            end else begin
                ok <= slot_req.cs && hit;
            end
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (done) begin
            tag    <= req_addr;
            cached <= fill;
        end
        // Address is frozen for the whole fetch
        if (miss && !req) begin
            req_addr <= slot_req.addr;
        end
    end

    assign rsp = '{ok: ok, data: cached};

    // Arbiter only answers a pending request
    a_done_on_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |-> req
    );

endmodule

`default_nettype wire

// ==== design/bank_arbiter.sv ====
// Fixed-priority arbiter that drains the ROM slots onto the single read-only bank port
`default_nettype none

`include "sdram_consts.svh"

module bank_arbiter (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`SLOTS-1:0]    req,
    input  sdram_pkg::ba_addr_t  req_addr [`SLOTS],
    output logic [`SLOTS-1:0]    done,
    output sdram_pkg::word_t     fill,
    output sdram_pkg::bank_req_t bank_req,
    input  sdram_pkg::bank_rsp_t bank_rsp
);

    localparam int IDX_W = $clog2(`SLOTS);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        WAIT_RDY
    } state_t;

    state_t           state;
    logic [IDX_W-1:0] gnt;
    logic [IDX_W-1:0] pick;
    logic             pending;

    // Lowest index wins
    always_comb begin
        pick    = '0;
        pending = 1'b0;
        for (int i = `SLOTS - 1; i >= 0; i--) begin
            if (req[i]) begin
                pick    = IDX_W'(i);
                pending = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= IDLE;
            bank_req.rd <= 1'b0;
            done        <= '0;
        end else begin
            done <= '0;
            case (state)
                IDLE: begin
                    // The finished slot still shows req while done is high
                    if (pending && done == '0) begin
                        gnt           <= pick;
                        bank_req.rd   <= 1'b1;
                        bank_req.addr <= req_addr[pick];
                        state         <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (bank_rsp.ack) begin
                        bank_req.rd <= 1'b0;
                        state       <= WAIT_RDY;
                    end
                end
                WAIT_RDY: begin
                    if (bank_rsp.rdy) begin
                        fill  <= bank_rsp.data;
                        done  <= `SLOTS'(1) << gnt;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/gfx_rom_bus.sv ====
// Graphics ROM bus top level joining the region mapper, four ROM slots and the bank arbiter
`default_nettype none

`include "sdram_consts.svh"

module gfx_rom_bus (
    input  logic                      clk,
    input  logic                      rst_n,
    input  gfx_pkg::gfx_req_t         gfx_req [`SLOTS],
    output wire gfx_pkg::gfx_rsp_t    gfx_rsp [`SLOTS],
    output wire sdram_pkg::bank_req_t bank_req,
    input  sdram_pkg::bank_rsp_t      bank_rsp
);

    wire gfx_pkg::slot_req_t  slot_req  [`SLOTS];
    wire sdram_pkg::ba_addr_t slot_addr [`SLOTS];
    wire [`SLOTS-1:0]         slot_rd;
    wire [`SLOTS-1:0]         slot_done;
    wire sdram_pkg::word_t    fill;

    rom_region_map u_map (
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .gfx_req    ( gfx_req   ),
        .slot_req   ( slot_req  )
    );

    // One slot per layer, in priority order
    for (genvar i = 0; i < `SLOTS; i++) begin : g_slot
        rom_slot u_slot (
            .clk        ( clk           ),
            .rst_n      ( rst_n         ),
            .slot_req   ( slot_req[i]   ),
            .req        ( slot_rd[i]    ),
            .req_addr   ( slot_addr[i]  ),
            .done       ( slot_done[i]  ),
            .fill       ( fill          ),
            .rsp        ( gfx_rsp[i]    )
        );
    end

    bank_arbiter u_arbiter (
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .req        ( slot_rd   ),
        .req_addr   ( slot_addr ),
        .done       ( slot_done ),
        .fill       ( fill      ),
        .bank_req   ( bank_req  ),
        .bank_rsp   ( bank_rsp  )
    );

endmodule

`default_nettype wire

// ==== tests/sdram_bank_model.sv ====
// Behavioral read-only SDRAM bank for the graphics ROM testbench, answering rd after random delays
`default_nettype none

`include "sdram_consts.svh"

module sdram_bank_model #(
    parameter sdram_pkg::word_t PATTERN   = '0,
    parameter int               LOG_DEPTH = 256
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  sdram_pkg::bank_req_t bank_req,
    output sdram_pkg::bank_rsp_t bank_rsp
);
    timeunit 1ns;
    timeprecision 1ps;

    // Addresses of all reads taken, in arrival order
    sdram_pkg::ba_addr_t log_addr [LOG_DEPTH];
    int                  read_count;

    // One read at a time, driven 1 ns after the edge
    initial begin : bank_proc
        int unsigned         delay;
        sdram_pkg::ba_addr_t addr;
        bank_rsp   = '0;
        read_count = 0;
        forever begin
            @(posedge clk);
            #1;
            if (rst_n && bank_req.rd) begin
                addr = bank_req.addr;
                if (read_count < LOG_DEPTH) begin
                    log_addr[read_count] = addr;
                end
                read_count++;
                // ack is sampled 1 to 4 edges after rd was seen
                delay = 1 + $urandom % 4;
                repeat (delay - 1) begin
                    @(posedge clk);
                    #1;
                end
                bank_rsp.ack = 1'b1;
                @(posedge clk);
                #1;
                bank_rsp.ack = 1'b0;
                // Then rdy lands 2 to 6 edges after ack
                delay = 2 + $urandom % 5;
                repeat (delay - 1) begin
                    @(posedge clk);
                    #1;
                end
                bank_rsp.rdy  = 1'b1;
                bank_rsp.data = sdram_pkg::word_t'(addr) ^ PATTERN;
                @(posedge clk);
                #1;
                bank_rsp.rdy  = 1'b0;
                bank_rsp.data = '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_gfx_rom_bus.sv ====
// Directed testbench for the graphics ROM bus, run with the bank model on the bank port
`default_nettype none

`include "sdram_consts.svh"

module tb_gfx_rom_bus;
    timeunit 1ns;
    timeprecision 1ps;

    localparam sdram_pkg::word_t PATTERN    = 32'h5a3c_96e1;
    localparam int unsigned      SEED       = 32'h06eaa603;
    localparam int               OK_TIMEOUT = 200;

    logic                      clk = 1'b0;
    logic                      rst_n;
    gfx_pkg::gfx_req_t         gfx_req [`SLOTS];
    wire gfx_pkg::gfx_rsp_t    gfx_rsp [`SLOTS];
    wire sdram_pkg::bank_req_t bank_req;
    wire sdram_pkg::bank_rsp_t bank_rsp;

    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    // Relative address each layer presented one and two edges back
    gfx_pkg::gfx_addr_t addr_d1 [`SLOTS];
    gfx_pkg::gfx_addr_t addr_d2 [`SLOTS];

    gfx_rom_bus i_gfx_rom_bus (
        .clk        ( clk      ),
        .rst_n      ( rst_n    ),
        .gfx_req    ( gfx_req  ),
        .gfx_rsp    ( gfx_rsp  ),
        .bank_req   ( bank_req ),
        .bank_rsp   ( bank_rsp )
    );

    sdram_bank_model #(.PATTERN(PATTERN)) i_bank (
        .clk        ( clk      ),
        .rst_n      ( rst_n    ),
        .bank_req   ( bank_req ),
        .bank_rsp   ( bank_rsp )
    );

    always #5 clk = ~clk;

    function automatic sdram_pkg::ba_addr_t region_offset(input gfx_pkg::layer_t layer);
        case (layer)
            gfx_pkg::CHAR: return `CHAR_OFFSET;
            gfx_pkg::SCR1: return `SCR1_OFFSET;
            gfx_pkg::SCR2: return `SCR2_OFFSET;
            default:       return `OBJ_OFFSET;
        endcase
    endfunction

    function automatic int unsigned region_words(input gfx_pkg::layer_t layer);
        case (layer)
            gfx_pkg::CHAR: return 32'(`CHAR_SIZE);
            gfx_pkg::OBJ:  return 32'(`OBJ_SIZE);
            default:       return 32'(`SCR_SIZE);
        endcase
    endfunction

    function automatic sdram_pkg::ba_addr_t abs_addr(input int l, input gfx_pkg::gfx_addr_t rel);
        return region_offset(gfx_pkg::layer_t'(l)) + sdram_pkg::ba_addr_t'(rel);
    endfunction

    // Bank contents: address zero-extended, XOR the pattern
    function automatic sdram_pkg::word_t expected_word(input sdram_pkg::ba_addr_t a);
        return sdram_pkg::word_t'(a) ^ PATTERN;
    endfunction

    function automatic gfx_pkg::gfx_addr_t random_addr(input int l);
        return gfx_pkg::gfx_addr_t'($urandom % region_words(gfx_pkg::layer_t'(l)));
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_word(input string name, input sdram_pkg::word_t got,
                              input sdram_pkg::word_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s: got %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input sdram_pkg::ba_addr_t got,
                              input sdram_pkg::ba_addr_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s: got %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t %s: got %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("ERR %0t %s: got %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("%0t: %s", $time, what);
        errors++;
    endtask

    task automatic end_test(input string name, input int err_base);
        tests_run++;
        if (errors == err_base) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, errors - err_base);
        end
    endtask

    task automatic check_quiet();
        check_flag("bank_req.rd", bank_req.rd, 1'b0);
        for (int l = 0; l < `SLOTS; l++) begin
            check_flag($sformatf("gfx_rsp[%0d].ok", l), gfx_rsp[l].ok, 1'b0);
        end
    endtask

    task automatic wait_ok(input int l);
        int n = 0;
        // ok still reflects the previous address for two edges
        step();
        step();
        while (gfx_rsp[l].ok !== 1'b1 && n < OK_TIMEOUT) begin
            step();
            n++;
        end
        if (gfx_rsp[l].ok !== 1'b1) begin
            report_failure($sformatf("layer %0d gave no ok within %0d cycles", l, OK_TIMEOUT));
        end
    endtask

    task automatic reset_quiet();
        int err_base = errors;
        rst_n = 1'b0;
        repeat (16) begin
            step();
            check_quiet();
        end
        rst_n = 1'b1;
        repeat (4) begin
            step();
            check_quiet();
        end
        end_test("reset", err_base);
    endtask

    task automatic fetch_each_layer();
        int                 err_base = errors;
        int                 base;
        gfx_pkg::gfx_addr_t rel;
        for (int l = 0; l < `SLOTS; l++) begin
            rel  = random_addr(l);
            base = i_bank.read_count;
            gfx_req[l].cs   = 1'b1;
            gfx_req[l].addr = rel;
            wait_ok(l);
            check_word($sformatf("gfx_rsp[%0d].data", l), gfx_rsp[l].data,
                       expected_word(abs_addr(l, rel)));
            check_count("bank read count", i_bank.read_count - base, 1);
            check_addr("bank read address", i_bank.log_addr[base], abs_addr(l, rel));
        end
        end_test("single fetch", err_base);
    endtask

    task automatic hit_holds();
        int err_base = errors;
        int base     = i_bank.read_count;
        repeat (8) begin
            step();
            for (int l = 0; l < `SLOTS; l++) begin
                check_flag($sformatf("gfx_rsp[%0d].ok", l), gfx_rsp[l].ok, 1'b1);
                check_word($sformatf("gfx_rsp[%0d].data", l), gfx_rsp[l].data,
                           expected_word(abs_addr(l, gfx_req[l].addr)));
            end
        end
        check_count("bank read count", i_bank.read_count - base, 0);
        end_test("hit", err_base);
    endtask

    task automatic contention_order();
        int                 err_base = errors;
        int                 base     = i_bank.read_count;
        gfx_pkg::gfx_addr_t rel [`SLOTS];
        // All four change on the same edge
        for (int l = 0; l < `SLOTS; l++) begin
            rel[l] = random_addr(l);
            if (rel[l] == gfx_req[l].addr) begin
                rel[l] ^= 18'h1;
            end
            gfx_req[l].addr = rel[l];
        end
        for (int l = 0; l < `SLOTS; l++) begin
            wait_ok(l);
            check_word($sformatf("gfx_rsp[%0d].data", l), gfx_rsp[l].data,
                       expected_word(abs_addr(l, rel[l])));
        end
        check_count("bank read count", i_bank.read_count - base, 4);
        for (int l = 0; l < `SLOTS; l++) begin
            check_addr($sformatf("bank read %0d address", l), i_bank.log_addr[base + l],
                       abs_addr(l, rel[l]));
        end
        end_test("priority", err_base);
    endtask

    task automatic change_in_flight();
        int                 err_base = errors;
        int                 base     = i_bank.read_count;
        int                 l        = int'(gfx_pkg::SCR2);
        int                 n        = 0;
        gfx_pkg::gfx_addr_t old_rel;
        gfx_pkg::gfx_addr_t new_rel;
        old_rel = random_addr(l);
        if (old_rel == gfx_req[l].addr) begin
            old_rel ^= 18'h1;
        end
        new_rel = old_rel ^ 18'h10;
        gfx_req[l].addr = old_rel;
        while (bank_req.rd !== 1'b1 && n < OK_TIMEOUT) begin
            step();
            n++;
        end
        if (bank_req.rd !== 1'b1) begin
            report_failure("bank rd never rose for the first address");
        end
        check_addr("bank_req.addr", bank_req.addr, abs_addr(l, old_rel));
        // Move while the first read still waits for ack
        gfx_req[l].addr = new_rel;
        wait_ok(l);
        check_word("gfx_rsp[2].data", gfx_rsp[l].data, expected_word(abs_addr(l, new_rel)));
        check_count("bank read count", i_bank.read_count - base, 2);
        check_addr("first bank read", i_bank.log_addr[base], abs_addr(l, old_rel));
        check_addr("second bank read", i_bank.log_addr[base + 1], abs_addr(l, new_rel));
        end_test("change during fetch", err_base);
    endtask

    task automatic idle_layers();
        int err_base = errors;
        int base     = i_bank.read_count;
        for (int l = 0; l < `SLOTS; l++) begin
            gfx_req[l].cs = 1'b0;
        end
        step();
        for (int l = 0; l < `SLOTS; l++) begin
            gfx_req[l].addr = random_addr(l);
        end
        repeat (50) begin
            step();
            check_flag("bank_req.rd", bank_req.rd, 1'b0);
        end
        check_count("bank read count", i_bank.read_count - base, 0);
        check_quiet();
        end_test("idle layers", err_base);
    endtask

    always @(posedge clk) begin
        for (int i = 0; i < `SLOTS; i++) begin
            addr_d2[i] <= addr_d1[i];
            addr_d1[i] <= gfx_req[i].addr;
        end
    end

    // Whenever ok is high, data belongs to the address presented two edges earlier
    always begin
        @(posedge clk);
        #1;
        if (rst_n) begin
            for (int i = 0; i < `SLOTS; i++) begin
                if (gfx_rsp[i].ok === 1'b1) begin
                    check_word($sformatf("gfx_rsp[%0d].data", i), gfx_rsp[i].data,
                               expected_word(abs_addr(i, addr_d2[i])));
                end
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        rst_n = 1'b0;
        for (int l = 0; l < `SLOTS; l++) begin
            gfx_req[l].cs   = 1'b0;
            gfx_req[l].addr = '0;
        end
        reset_quiet();
        fetch_each_layer();
        hit_holds();
        contention_order();
        change_in_flight();
        idle_layers();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+design
design/sdram_pkg.sv
design/gfx_pkg.sv
design/rom_region_map.sv
design/rom_slot.sv
design/bank_arbiter.sv
design/gfx_rom_bus.sv
tests/sdram_bank_model.sv
tests/tb_gfx_rom_bus.sv

// ==== Makefile ====
# Verilator lint and simulation of the graphics ROM bus testbench
VERILATOR ?= verilator
TOP       ?= tb_gfx_rom_bus
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# The run passes only when the testbench prints the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
